// ==== status_pkg.sv ====
package status_pkg;

    typedef logic [31:0] axi_data_t;
    typedef logic [31:0] axi_addr_t;   // word address
    typedef logic [3:0]  axi_strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;    // beats minus one
    typedef logic [15:0] rstn_vec_t;   // one bit per bus master or slave
    typedef logic [7:0]  power_vec_t;  // one bit per supply port
    typedef logic [31:0] ip_addr_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } axi_burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    localparam axi_addr_t ADDR_AXI_INIT     = 32'h0000_0000; // bus reset status, ro
    localparam axi_addr_t ADDR_AXI_RESET    = 32'h0000_0001; // bus reset pulses, wo
    localparam axi_addr_t ADDR_UID_HI       = 32'h0000_0002; // ro
    localparam axi_addr_t ADDR_UID_LO       = 32'h0000_0003; // ro
    localparam axi_addr_t ADDR_POWER_STATUS = 32'h0000_0004; // rw
    localparam axi_addr_t ADDR_POWER_RESET  = 32'h0000_0005; // power reset pulse, wo
    localparam axi_addr_t ADDR_HOST_IP      = 32'h0000_0006; // rw
    localparam axi_addr_t ADDR_BOARD_IP     = 32'h0000_0007; // rw
    localparam axi_addr_t ADDR_LAST         = 32'h0000_0007;
    localparam axi_data_t RD_ILLEGAL_DATA   = 32'hFFFF_FFFF;

    typedef struct packed {
        logic      en;
        axi_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
    } reg_wr_t;

    typedef struct packed {
        rstn_vec_t master_rstn;  // 1 = running, 0 = held in reset
        rstn_vec_t slave_rstn;
        axi_data_t uid_high;
        axi_data_t uid_low;
    } sys_status_t;

    typedef struct packed {
        rstn_vec_t  axi_master_reset;
        rstn_vec_t  axi_slave_reset;
        power_vec_t power_reset;
    } reset_pulse_t;

    typedef struct packed {
        ip_addr_t host_ip;
        ip_addr_t board_ip;
    } net_cfg_t;

    function automatic logic wr_addr_legal(axi_addr_t addr);
        return (addr <= ADDR_LAST) && (addr != ADDR_UID_HI) && (addr != ADDR_UID_LO);
    endfunction

    function automatic logic rd_addr_legal(axi_addr_t addr);
        return (addr <= ADDR_LAST) && (addr != ADDR_AXI_RESET) && (addr != ADDR_POWER_RESET);
    endfunction

endpackage

// ==== status_regfile.sv ====
module status_regfile import status_pkg::*; (
    input  logic         clk,
    input  logic         STATUS_SLAVE_RSTN_SYNC,
    input  reg_wr_t      reg_wr,
    input  axi_addr_t    rd_addr,
    input  sys_status_t  sys_status,
    output axi_data_t    rd_data,
    output reset_pulse_t reset_pulse,
    output power_vec_t   power_status,
    output net_cfg_t     net_cfg
);

    localparam int PWR_W  = $bits(power_vec_t);
    localparam int RSTN_W = $bits(rstn_vec_t);

    axi_data_t wr_mask;     // strobes spread over byte lanes
    axi_data_t wr_bits;     // write data under the strobes
    logic      wr_bus_rst;
    logic      wr_pwr;
    logic      wr_pwr_rst;
    logic      wr_host;
    logic      wr_board;

    always_comb begin
        for (int i = 0; i < $bits(axi_strb_t); i++) begin
            wr_mask[8*i +: 8] = {8{reg_wr.strb[i]}};
        end
    end

    assign wr_bits    = reg_wr.data & wr_mask;
    assign wr_bus_rst = reg_wr.en && (reg_wr.addr == ADDR_AXI_RESET);
    assign wr_pwr     = reg_wr.en && (reg_wr.addr == ADDR_POWER_STATUS);
    assign wr_pwr_rst = reg_wr.en && (reg_wr.addr == ADDR_POWER_RESET);
    assign wr_host    = reg_wr.en && (reg_wr.addr == ADDR_HOST_IP);
    assign wr_board   = reg_wr.en && (reg_wr.addr == ADDR_BOARD_IP);

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            power_status <= '0;
            net_cfg      <= '0;
        end else begin
            if (wr_pwr) begin
                power_status <= (power_status & ~wr_mask[PWR_W-1:0]) | wr_bits[PWR_W-1:0];
            end
            if (wr_host) begin
                net_cfg.host_ip <= (net_cfg.host_ip & ~wr_mask) | wr_bits;
            end
            if (wr_board) begin
                net_cfg.board_ip <= (net_cfg.board_ip & ~wr_mask) | wr_bits;
            end
        end
    end

    // one cycle per beat; a bit already high is not stretched by a back-to-back beat
    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            reset_pulse <= '0;
        end else begin
            reset_pulse <= '0;
            if (wr_bus_rst) begin
                reset_pulse.axi_master_reset <= wr_bits[2*RSTN_W-1:RSTN_W]
                                                & ~reset_pulse.axi_master_reset;
                reset_pulse.axi_slave_reset  <= wr_bits[RSTN_W-1:0]
                                                & ~reset_pulse.axi_slave_reset;
            end
            if (wr_pwr_rst) begin
                reset_pulse.power_reset <= wr_bits[PWR_W-1:0] & ~reset_pulse.power_reset;
            end
        end
    end

    always_comb begin
        case (rd_addr)
            ADDR_AXI_INIT:     rd_data = {sys_status.master_rstn, sys_status.slave_rstn};
            ADDR_UID_HI:       rd_data = sys_status.uid_high;
            ADDR_UID_LO:       rd_data = sys_status.uid_low;
            ADDR_POWER_STATUS: rd_data = axi_data_t'(power_status);
            ADDR_HOST_IP:      rd_data = net_cfg.host_ip;
            ADDR_BOARD_IP:     rd_data = net_cfg.board_ip;
            default:           rd_data = RD_ILLEGAL_DATA;  // write only or unmapped
        endcase
    end

    a_pulse_one_cycle: assert property (
        @(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        !(|(reset_pulse & $past(reset_pulse)))
    );

endmodule

// ==== status_wr_channel.sv ====
module status_wr_channel import status_pkg::*; (
    input  logic       clk,
    input  logic       STATUS_SLAVE_RSTN_SYNC,
    input  axi_id_t    awid,
    input  axi_addr_t  awaddr,
    input  axi_burst_e awburst,
    input  logic       awvalid,
    output logic       awready,
    input  axi_data_t  wdata,
    input  axi_strb_t  wstrb,
    input  logic       wlast,
    input  logic       wvalid,
    output logic       wready,
    output axi_id_t    bid,
    output axi_resp_e  bresp,
    output logic       bvalid,
    input  logic       bready,
    output reg_wr_t    reg_wr
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e  state, state_nxt;
    axi_burst_e burst_q;
    axi_addr_t  addr_q;     // address of the current beat
    logic       err_q;      // sticky for the whole burst
    logic       aw_hs, w_hs, b_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: if (aw_hs) state_nxt = WR_DATA;
            WR_DATA: if (w_hs && wlast) state_nxt = WR_RESP;  // no awlen, wlast ends it
            WR_RESP: if (b_hs) state_nxt = WR_IDLE;
            default: state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state <= WR_IDLE;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (aw_hs) begin
                err_q <= awburst inside {BURST_WRAP, BURST_RSVD};
            end else if (w_hs && !wr_addr_legal(addr_q)) begin
                err_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            bid     <= awid;
            burst_q <= awburst;
            addr_q  <= awaddr;
        end else if (w_hs && (burst_q == BURST_INCR)) begin
            addr_q <= addr_q + 1'b1;  // fixed bursts stay put
        end
    end

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign bresp   = err_q ? RESP_SLVERR : RESP_OKAY;

    // regfile decodes the address, unmapped beats change nothing
    assign reg_wr = '{en: w_hs, addr: addr_q, data: wdata, strb: wstrb};

    a_bresp_hold: assert property (
        @(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp)
    );

endmodule

// ==== status_rd_channel.sv ====
module status_rd_channel import status_pkg::*; (
    input  logic       clk,
    input  logic       STATUS_SLAVE_RSTN_SYNC,
    input  axi_id_t    arid,
    input  axi_addr_t  araddr,
    input  axi_len_t   arlen,
    input  axi_burst_e arburst,
    input  logic       arvalid,
    output logic       arready,
    output axi_id_t    rid,
    output axi_data_t  rdata,
    output axi_resp_e  rresp,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready,
    output axi_addr_t  rd_addr,
    input  axi_data_t  rd_data
);

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

    rd_state_e  state;
    axi_len_t   len_q;
    axi_len_t   beat_q;     // beats already accepted
    axi_burst_e burst_q;
    axi_addr_t  addr_q;     // address of the beat on the bus
    logic       err_q;      // sticky from the first bad beat on
    logic       ar_hs, r_hs;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // address of the next beat, fetched while the current one is taken
    always_comb begin
        rd_addr = addr_q;
        if (ar_hs) begin
            rd_addr = araddr;
        end else if (r_hs && (burst_q == BURST_INCR)) begin
            rd_addr = addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state  <= RD_IDLE;
            len_q  <= '0;
            beat_q <= '0;
            err_q  <= 1'b0;
        end else if (ar_hs) begin
            state  <= RD_DATA;
            len_q  <= arlen;
            beat_q <= '0;
            err_q  <= (arburst inside {BURST_WRAP, BURST_RSVD}) || !rd_addr_legal(araddr);
        end else if (r_hs) begin
            if (rlast) begin
                state <= RD_IDLE;
            end
            beat_q <= beat_q + 1'b1;
            err_q  <= err_q || !rd_addr_legal(rd_addr);
        end
    end

    // beat payload only moves on a handshake, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rid     <= arid;
            burst_q <= arburst;
        end
        if (ar_hs || r_hs) begin
            addr_q <= rd_addr;
            rdata  <= rd_data;
        end
    end

    assign arready = (state == RD_IDLE);
    assign rvalid  = (state == RD_DATA);
    assign rlast   = rvalid && (beat_q == len_q);
    assign rresp   = err_q ? RESP_SLVERR : RESP_OKAY;

    a_rbeat_hold: assert property (
        @(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast)
    );

endmodule

// ==== status_axi_slave.sv ====
module status_axi_slave import status_pkg::*; (
    input  logic         clk,
    input  logic         STATUS_SLAVE_RSTN_SYNC,
    input  axi_id_t      awid,
    input  axi_addr_t    awaddr,
    input  axi_burst_e   awburst,
    input  logic         awvalid,
    output logic         awready,
    input  axi_data_t    wdata,
    input  axi_strb_t    wstrb,
    input  logic         wlast,
    input  logic         wvalid,
    output logic         wready,
    output axi_id_t      bid,
    output axi_resp_e    bresp,
    output logic         bvalid,
    input  logic         bready,
    input  axi_id_t      arid,
    input  axi_addr_t    araddr,
    input  axi_len_t     arlen,
    input  axi_burst_e   arburst,
    input  logic         arvalid,
    output logic         arready,
    output axi_id_t      rid,
    output axi_data_t    rdata,
    output axi_resp_e    rresp,
    output logic         rlast,
    output logic         rvalid,
    input  logic         rready,
    input  sys_status_t  sys_status,
    output reset_pulse_t reset_pulse,
    output power_vec_t   power_status,
    output net_cfg_t     net_cfg
);

    reg_wr_t   reg_wr;   // write command, one per accepted beat
    axi_addr_t rd_addr;
    axi_data_t rd_data;

    status_wr_channel u_wr_channel (
        .clk, .STATUS_SLAVE_RSTN_SYNC,
        .awid, .awaddr, .awburst, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bid, .bresp, .bvalid, .bready,
        .reg_wr
    );

    status_rd_channel u_rd_channel (
        .clk, .STATUS_SLAVE_RSTN_SYNC,
        .arid, .araddr, .arlen, .arburst, .arvalid, .arready,
        .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
        .rd_addr, .rd_data
    );

    status_regfile u_regfile (
        .clk, .STATUS_SLAVE_RSTN_SYNC,
        .reg_wr, .rd_addr, .sys_status,
        .rd_data, .reset_pulse, .power_status, .net_cfg
    );

endmodule

// ==== tb_status_axi_slave.sv ====
module tb_status_axi_slave import status_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;  // cycles per wait

    logic         clk;
    logic         STATUS_SLAVE_RSTN_SYNC;
    axi_id_t      awid, bid, arid, rid;
    axi_addr_t    awaddr, araddr;
    axi_burst_e   awburst, arburst;
    axi_len_t     arlen;
    axi_data_t    wdata, rdata;
    axi_strb_t    wstrb;
    axi_resp_e    bresp, rresp;
    logic         awvalid, awready, wlast, wvalid, wready, bvalid;
    logic         arvalid, arready, rlast, rvalid;
    logic         bready = 1'b1;
    logic         rready = 1'b1;
    sys_status_t  sys_status;
    reset_pulse_t reset_pulse, m_pulse;
    power_vec_t   power_status, m_power;
    net_cfg_t     net_cfg, m_net;

    logic [31:0]  seed = 32'd15;
    logic         rand_ready = 1'b0;    // random bready and rready
    int           errs, errs_base, n_pass, n_fail;
    event         timed_out;
    axi_addr_t    wm_addr, rm_addr;     // model beat addresses
    axi_burst_e   wm_burst, rm_burst;
    axi_id_t      wm_id, rm_id;
    logic         wm_err, rm_err;
    axi_len_t     rm_len, rm_beat;
    axi_data_t    w_bits, exp_rdata;
    axi_resp_e    exp_rresp;

    status_axi_slave u_status_axi_slave (.*);

    function automatic logic [15:0] rnd();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];  // low bits of the LCG are weak
    endfunction

    function automatic axi_data_t strobe_merge(axi_data_t old, axi_data_t nw, axi_strb_t s);
        axi_data_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) r[8*b +: 8] = nw[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic wr_ok(axi_addr_t a);
        case (a)
            0, 1, 4, 5, 6, 7: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic rd_ok(axi_addr_t a);
        case (a)
            0, 2, 3, 4, 6, 7: return 1'b1;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic chan_ready(input int ch);
        case (ch)
            0:       return awready;
            1:       return wready;
            2:       return bvalid && bready;
            3:       return arready;
            default: return rvalid && rready;
        endcase
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                   input logic [63:0] got);
        errs++;
        $display("Fail %s exp %0h got %0h", sig, exp, got);
    endtask

    task automatic report_event(input string what);
        errs++;
        $display("%s", what);
    endtask

    // returns on the negedge before the edge that completes the handshake
    task automatic wait_on(input int ch, input string what);
        int t;
        t = 0;
        @(negedge clk);
        while (!chan_ready(ch) && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!chan_ready(ch)) begin
            $display("timeout waiting for %s", what);
            -> timed_out;
            forever @(negedge clk);
        end
    endtask

    task automatic write_burst(input axi_addr_t addr, input axi_burst_e burst, input int nbeats,
                               input logic rand_strb);
        @(posedge clk);
        awid    <= axi_id_t'(rnd());
        awaddr  <= addr;
        awburst <= burst;
        awvalid <= 1'b1;
        wait_on(0, "awready");
        @(posedge clk);
        awvalid <= 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            wdata  <= {rnd(), rnd()};
            wstrb  <= rand_strb ? axi_strb_t'(rnd()) : 4'hF;
            wlast  <= (i == nbeats - 1);
            wvalid <= 1'b1;
            wait_on(1, "wready");
            @(posedge clk);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        wait_on(2, "write response");
        @(posedge clk);
    endtask

    task automatic read_burst(input axi_addr_t addr, input axi_len_t len, input axi_burst_e burst);
        int   beats;
        logic done;
        beats = 0;
        done  = 1'b0;
        @(posedge clk);
        arid    <= axi_id_t'(rnd());
        araddr  <= addr;
        arlen   <= len;
        arburst <= burst;
        arvalid <= 1'b1;
        wait_on(3, "arready");
        @(posedge clk);
        arvalid <= 1'b0;
        while (!done) begin
            wait_on(4, "read beat");
            beats++;
            done = rlast;
            @(posedge clk);
        end
        assert (beats == int'(len) + 1)
            else report_mismatch("beat count", int'(len) + 1, beats);
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);  // let the last assertions settle
        if (errs == errs_base) begin
            n_pass++;
            $display("%s: ok", name);
        end else begin
            n_fail++;
            $display("%s: %0d errors", name, errs - errs_base);
        end
        errs_base = errs;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        bready <= rand_ready ? (rnd() > 16'h5000) : 1'b1;
        rready <= rand_ready ? (rnd() > 16'h5000) : 1'b1;
    end

    assign w_bits = strobe_merge('0, wdata, wstrb);

    // write side model, registers and pulses
    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            wm_addr  <= '0;
            wm_burst <= BURST_FIXED;
            wm_id    <= '0;
            wm_err   <= 1'b0;
            m_power  <= '0;
            m_net    <= '0;
            m_pulse  <= '0;
        end else begin
            m_pulse <= '0;
            if (awvalid && awready) begin
                wm_addr  <= awaddr;
                wm_burst <= awburst;
                wm_id    <= awid;
                wm_err   <= (awburst == BURST_WRAP) || (awburst == BURST_RSVD);
            end else if (wvalid && wready) begin
                if (wm_burst == BURST_INCR) wm_addr <= wm_addr + 32'd1;
                if (!wr_ok(wm_addr)) wm_err <= 1'b1;
                case (wm_addr)
                    ADDR_AXI_RESET: begin
                        m_pulse.axi_master_reset <= w_bits[31:16] & ~m_pulse.axi_master_reset;
                        m_pulse.axi_slave_reset  <= w_bits[15:0] & ~m_pulse.axi_slave_reset;
                    end
                    ADDR_POWER_STATUS: begin
                        m_power <= power_vec_t'(strobe_merge(32'(m_power), wdata, wstrb));
                    end
                    ADDR_POWER_RESET:  m_pulse.power_reset <= w_bits[7:0] & ~m_pulse.power_reset;
                    ADDR_HOST_IP:      m_net.host_ip <= strobe_merge(m_net.host_ip, wdata, wstrb);
                    ADDR_BOARD_IP:     m_net.board_ip <= strobe_merge(m_net.board_ip, wdata, wstrb);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            rm_addr  <= '0;
            rm_burst <= BURST_FIXED;
            rm_id    <= '0;
            rm_err   <= 1'b0;
            rm_len   <= '0;
            rm_beat  <= '0;
        end else if (arvalid && arready) begin
            rm_addr  <= araddr;
            rm_burst <= arburst;
            rm_id    <= arid;
            rm_err   <= (arburst == BURST_WRAP) || (arburst == BURST_RSVD);
            rm_len   <= arlen;
            rm_beat  <= '0;
        end else if (rvalid && rready) begin
            if (rm_burst == BURST_INCR) rm_addr <= rm_addr + 32'd1;
            rm_err  <= rm_err || !rd_ok(rm_addr);
            rm_beat <= rm_beat + 8'd1;
        end
    end

    always_comb begin
        case (rm_addr)
            ADDR_AXI_INIT:     exp_rdata = {sys_status.master_rstn, sys_status.slave_rstn};
            ADDR_UID_HI:       exp_rdata = sys_status.uid_high;
            ADDR_UID_LO:       exp_rdata = sys_status.uid_low;
            ADDR_POWER_STATUS: exp_rdata = {24'h0, m_power};
            ADDR_HOST_IP:      exp_rdata = m_net.host_ip;
            ADDR_BOARD_IP:     exp_rdata = m_net.board_ip;
            default:           exp_rdata = 32'hFFFF_FFFF;
        endcase
    end

    assign exp_rresp = (rm_err || !rd_ok(rm_addr)) ? RESP_SLVERR : RESP_OKAY;

    a_rdata: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rvalid |-> rdata == exp_rdata)
        else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));
    a_rresp: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rvalid |-> rresp == exp_rresp)
        else report_mismatch("rresp", $sampled(exp_rresp), $sampled(rresp));
    a_rid: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rvalid |-> rid == rm_id)
        else report_mismatch("rid", $sampled(rm_id), $sampled(rid));
    a_rlast: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rvalid |-> rlast == (rm_beat == rm_len))
        else report_mismatch("rlast", $sampled(rm_beat == rm_len), $sampled(rlast));
    a_bresp: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        bvalid |-> bresp == (wm_err ? RESP_SLVERR : RESP_OKAY))
        else report_mismatch("bresp", $sampled(wm_err) ? 2'h2 : 2'h0, $sampled(bresp));
    a_bid: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        bvalid |-> bid == wm_id)
        else report_mismatch("bid", $sampled(wm_id), $sampled(bid));
    a_power: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        power_status == m_power)
        else report_mismatch("power_status", $sampled(m_power), $sampled(power_status));
    a_net: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        net_cfg == m_net)
        else report_mismatch("net_cfg", $sampled(m_net), $sampled(net_cfg));
    a_pulse: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        reset_pulse == m_pulse)
        else report_mismatch("reset_pulse", $sampled(m_pulse), $sampled(reset_pulse));
    a_bhold: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        bvalid && !bready |=> bvalid)
        else report_event("bvalid dropped before bready");
    a_rhold: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else report_event("read beat changed before rready");

    initial begin
        @(timed_out);
        $display("Test failed");
        $finish;
    end

    initial begin
        STATUS_SLAVE_RSTN_SYNC = 1'b0;
        {awid, awaddr, awvalid, wdata, wstrb, wlast, wvalid} = '0;
        {arid, araddr, arlen, arvalid} = '0;
        awburst    = BURST_INCR;
        arburst    = BURST_INCR;
        sys_status = '0;
        repeat (4) @(posedge clk);
        STATUS_SLAVE_RSTN_SYNC <= 1'b1;
        @(negedge clk);
        assert ({awready, arready, bvalid, rvalid, wready} == 5'b11000)
            else report_mismatch("handshake", 64'h18, {awready, arready, bvalid, rvalid, wready});
        end_test("reset values");

        write_burst(ADDR_HOST_IP, BURST_INCR, 2, 1'b1);
        write_burst(ADDR_POWER_STATUS, BURST_INCR, 1, 1'b1);
        read_burst(ADDR_HOST_IP, 8'd1, BURST_INCR);
        end_test("config write and readback");

        write_burst(ADDR_AXI_RESET, BURST_INCR, 1, 1'b1);
        write_burst(ADDR_POWER_RESET, BURST_INCR, 1, 1'b0);
        end_test("reset pulses");

        sys_status <= '{master_rstn: 16'hA5C3, slave_rstn: 16'h0FF0,
                        uid_high: 32'h1234_5678, uid_low: 32'h9ABC_DEF0};
        read_burst(ADDR_AXI_INIT, 8'd3, BURST_INCR);  // beat 1 is write only
        end_test("status readback");

        write_burst(ADDR_UID_HI, BURST_INCR, 1, 1'b0);
        read_burst(ADDR_POWER_STATUS, 8'd2, BURST_WRAP);
        read_burst(ADDR_HOST_IP, 8'd3, BURST_INCR);   // runs past the map
        end_test("error responses");

        rand_ready = 1'b1;
        write_burst(ADDR_HOST_IP, BURST_INCR, 2, 1'b1);
        read_burst(ADDR_POWER_STATUS, 8'd3, BURST_INCR);
        read_burst(ADDR_BOARD_IP, 8'd2, BURST_FIXED);
        rand_ready = 1'b0;
        end_test("back-pressure");

        $display("tests: %0d ok, %0d failing", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
status_pkg.sv
status_regfile.sv
status_wr_channel.sv
status_rd_channel.sv
status_axi_slave.sv
tb_status_axi_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the AXI status slave testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_status_axi_slave \
    -f vlog.f --Mdir obj_dir -o tb_status_axi_slave
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_status_axi_slave > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1
